/* vdec_params.svh */
// widths and counts shared by the vector decoder package and its testbench
`ifndef VDEC_PARAMS_SVH
`define VDEC_PARAMS_SVH

// scalar operand and instruction word width
`define VDEC_XLEN 32

// vector register file has 32 entries
`define VDEC_VREG_AW 5

// vector length, 1 to 16 elements
`define VDEC_VL_W 5

// immediate operand width, vsetvli carries 11 bits of vtype
`define VDEC_IMM_W 11

// beat counter, four lanes per beat so at most four beats
`define VDEC_BEAT_W 2

`endif

/* vdec_pkg.sv */
// types shared by the vector decoder blocks, imported by each module that uses them
`include "vdec_params.svh"

package vdec_pkg;

typedef enum logic {WAIT, EXEC} vdec_state_t;

typedef enum logic [6:0] {
    V_MAJOR_LOAD_FP  = 7'h07,
    V_MAJOR_STORE_FP = 7'h27,
    V_MAJOR_OP_V     = 7'h57
} v_major_t;

// OPCFG also encodes the width code 111 of vector loads and stores
typedef enum logic [2:0] {
    V_OPIVV = 3'b000,
    V_OPMVV = 3'b010,
    V_OPIVI = 3'b011,
    V_OPIVX = 3'b100,
    V_OPMVX = 3'b110,
    V_OPCFG = 3'b111
} v_funct3_t;

typedef enum logic [5:0] {
    V_F6_ADD      = 6'b000000,
    V_F6_SUB      = 6'b000010,
    V_F6_MIN      = 6'b000101,
    V_F6_MAX      = 6'b000111,
    V_F6_AND      = 6'b001001,
    V_F6_OR       = 6'b001010,
    V_F6_XOR      = 6'b001011,
    V_F6_WXUNARY0 = 6'b010000,
    V_F6_MV       = 6'b010111,
    V_F6_SLL_MUL  = 6'b100101,
    V_F6_SRL      = 6'b101000,
    V_F6_SRA      = 6'b101001
} v_funct6_t;

typedef enum logic [1:0] {SEW_8, SEW_16, SEW_32} sew_t;

typedef enum logic [3:0] {
    PE_ARITH_ADD,
    PE_ARITH_SUB,
    PE_ARITH_AND,
    PE_ARITH_OR,
    PE_ARITH_XOR,
    PE_ARITH_LSHIFT,
    PE_ARITH_RSHIFT_LOG,
    PE_ARITH_RSHIFT_AR,
    PE_ARITH_MUL
} pe_arith_op_t;

typedef enum logic [1:0] {
    PE_OPERAND_VS1,
    PE_OPERAND_SCALAR,
    PE_OPERAND_IMMEDIATE,
    PE_OPERAND_RIPPLE
} pe_operand_t;

typedef enum logic [1:0] {
    PE_OP_MODE_RESULT,
    PE_OP_MODE_PASS_MIN,
    PE_OP_MODE_PASS_MAX
} pe_output_mode_t;

typedef enum logic [1:0] {
    VREG_WB_SRC_ARITH,
    VREG_WB_SRC_MEMORY,
    VREG_WB_SRC_SCALAR
} vreg_wb_src_t;

typedef enum logic {VS3_ADDR_SRC_DECODE, VS3_ADDR_SRC_VLSU} vs3_addr_src_t;

typedef enum logic {APU_RESULT_SRC_VL, APU_RESULT_SRC_VS2_0} apu_result_src_t;

typedef struct packed {
    logic [`VDEC_XLEN-1:0] instr;
    logic [`VDEC_XLEN-1:0] scalar1;
    logic [`VDEC_XLEN-1:0] scalar2;
} apu_req_t;

typedef struct packed {
    v_major_t                major;
    v_funct3_t               funct3;
    v_funct6_t               funct6;
    logic [`VDEC_VREG_AW-1:0] vs1;
    logic [`VDEC_VREG_AW-1:0] vs2;
    logic [`VDEC_VREG_AW-1:0] vd;
    logic [`VDEC_IMM_W-1:0]   imm;
} instr_fields_t;

typedef struct packed {
    pe_arith_op_t    op;
    pe_operand_t     operand;
    pe_output_mode_t output_mode;
    vreg_wb_src_t    vd_data_src;
} pe_ctrl_t;

typedef struct packed {
    logic            write;
    logic            preserve_vl;
    logic            set_vl_max;
    apu_result_src_t result_src;
} csr_ctrl_t;

typedef struct packed {
    logic en;
    logic load;
    logic store;
    logic strided;
} vlsu_ctrl_t;

typedef struct packed {
    logic [`VDEC_VREG_AW-1:0] vs1_addr;
    logic [`VDEC_VREG_AW-1:0] vs2_addr;
    logic [`VDEC_VREG_AW-1:0] vd_addr;
    vs3_addr_src_t            vs3_src;
    logic                     write;
    logic [1:0]               elements_to_write;
} vreg_ctrl_t;

endpackage

/* vdec_instr_reg.sv */
// instruction register, latches the APU request on grant and splits the instruction word
`timescale 1ns/100ps
`include "vdec_params.svh"

module vdec_instr_reg
    import vdec_pkg::*;
(
    input  logic                  clk,
    input  logic                  n_reset,
    input  logic                  capture_i,
    input  logic                  apu_req_i,
    input  apu_req_t              apu_data_i,
    output instr_fields_t         fields_o,
    output logic [`VDEC_XLEN-1:0] scalar1_o,
    output logic [`VDEC_XLEN-1:0] scalar2_o
);

apu_req_t req_q;

// held for the whole instruction, the core may change the port meanwhile
always_ff @(posedge clk, negedge n_reset)
begin
    if (!n_reset)
        req_q <= '0;
    else if (capture_i && apu_req_i)
        req_q <= apu_data_i;
end

// standard vector instruction layout
always_comb
begin
    fields_o.major  = v_major_t'(req_q.instr[6:0]);
    fields_o.funct3 = v_funct3_t'(req_q.instr[14:12]);
    fields_o.funct6 = v_funct6_t'(req_q.instr[31:26]);
    fields_o.vs1    = req_q.instr[19:15];
    fields_o.vs2    = req_q.instr[24:20];
    fields_o.vd     = req_q.instr[11:7];
    // vtype immediate of vsetvli
    fields_o.imm    = req_q.instr[30:20];
end

assign scalar1_o = req_q.scalar1;
assign scalar2_o = req_q.scalar2;

endmodule

/* vdec_ctrl_fsm.sv */
// decoder sequencer, runs the APU grant/valid handshake, core halt and the beat counter
`timescale 1ns/100ps
`include "vdec_params.svh"

module vdec_ctrl_fsm
    import vdec_pkg::*;
(
    input  logic                    clk,
    input  logic                    n_reset,
    input  logic                    apu_req_i,
    input  logic                    vlsu_done_i,
    input  logic                    multi_beat_i,
    input  logic                    mem_op_i,
    input  logic [`VDEC_VL_W-1:0]   vl_i,
    output logic                    capture_o,
    output logic                    exec_o,
    output logic                    apu_gnt_o,
    output logic                    apu_rvalid_o,
    output logic                    core_halt_o,
    output logic [`VDEC_BEAT_W-1:0] beat_o,
    output logic                    last_beat_o
);

vdec_state_t             state;
vdec_state_t             next_state;
logic [`VDEC_VL_W-1:0]   vl_m1;
logic [`VDEC_BEAT_W-1:0] last_idx;
logic                    at_last;
logic                    done;

// four lanes per beat, last index is (vl - 1) / 4
assign vl_m1    = vl_i - 1'b1;
assign last_idx = multi_beat_i ? vl_m1[`VDEC_BEAT_W+1:2] : '0;
assign at_last  = (beat_o == last_idx);

// memory ops wait on the VLSU, everything else on the beat count
assign done = exec_o && (mem_op_i ? vlsu_done_i : at_last);

always_comb
begin
    next_state = state;
    case (state)
        WAIT:
            if (apu_req_i)
                next_state = EXEC;
        EXEC:
            if (done)
                next_state = WAIT;
        default:
            next_state = WAIT;
    endcase
end

always_ff @(posedge clk, negedge n_reset)
begin
    if (!n_reset)
    begin
        state  <= WAIT;
        beat_o <= '0;
    end
    else
    begin
        state <= next_state;
        // beat stays at 0 for memory ops and restarts for every instruction
        if (!exec_o || mem_op_i || done)
            beat_o <= '0;
        else
            beat_o <= beat_o + 1'b1;
    end
end

assign capture_o    = (state == WAIT);
assign apu_gnt_o    = capture_o;
assign exec_o       = (state == EXEC);
assign core_halt_o  = exec_o;
assign apu_rvalid_o = done;
assign last_beat_o  = exec_o && multi_beat_i && at_last;

endmodule

/* vdec_op_decode.sv */
// opcode decoder, maps the captured instruction fields onto PE, CSR, VLSU and register controls
`timescale 1ns/100ps

module vdec_op_decode
    import vdec_pkg::*;
(
    input  logic          exec_i,
    input  instr_fields_t fields_i,
    output pe_ctrl_t      pe_o,
    output csr_ctrl_t     csr_o,
    output vlsu_ctrl_t    vlsu_o,
    output vs3_addr_src_t vs3_src_o,
    output logic          vreg_write_o,
    output logic          fix_vd_o,
    output logic          multi_beat_o,
    output logic          mem_op_o
);

pe_operand_t operand_f3;
logic        reduction;
logic        vec_op;

// second operand follows the funct3 category
always_comb
begin
    case (fields_i.funct3)
        V_OPIVX, V_OPMVX: operand_f3 = PE_OPERAND_SCALAR;
        V_OPIVI:          operand_f3 = PE_OPERAND_IMMEDIATE;
        default:          operand_f3 = PE_OPERAND_VS1;
    endcase
end

// OPMVV form of add and max is the reduction
assign reduction = (fields_i.funct3 == V_OPMVV);

always_comb
begin
    // idle defaults, no writes and no VLSU activity
    pe_o.op           = PE_ARITH_ADD;
    pe_o.operand      = PE_OPERAND_VS1;
    pe_o.output_mode  = PE_OP_MODE_RESULT;
    pe_o.vd_data_src  = VREG_WB_SRC_ARITH;
    csr_o.write       = 1'b0;
    csr_o.preserve_vl = 1'b0;
    csr_o.set_vl_max  = 1'b0;
    csr_o.result_src  = APU_RESULT_SRC_VL;
    vlsu_o            = '0;
    vs3_src_o         = VS3_ADDR_SRC_DECODE;
    fix_vd_o          = 1'b0;
    vec_op            = 1'b0;

    if (exec_i)
    begin
        case (fields_i.major)
            V_MAJOR_LOAD_FP:
            begin
                if (fields_i.funct3 == V_OPCFG)
                begin
                    pe_o.vd_data_src = VREG_WB_SRC_MEMORY;
                    vlsu_o.en        = 1'b1;
                    vlsu_o.load      = 1'b1;
                    // mop field sits in the low funct6 bits
                    vlsu_o.strided   = (fields_i.funct6[2:0] == 3'b010);
                end
            end
            V_MAJOR_STORE_FP:
            begin
                if (fields_i.funct3 == V_OPCFG)
                begin
                    vs3_src_o    = VS3_ADDR_SRC_VLSU;
                    fix_vd_o     = 1'b1;
                    vlsu_o.en    = 1'b1;
                    vlsu_o.store = 1'b1;
                end
            end
            V_MAJOR_OP_V:
            begin
                if (fields_i.funct3 == V_OPCFG)
                begin
                    // vsetvli, rs1=x0 keeps vl or sets it to max depending on rd
                    csr_o.write       = 1'b1;
                    csr_o.preserve_vl = (fields_i.vs1 == '0) && (fields_i.vd == '0);
                    csr_o.set_vl_max  = (fields_i.vs1 == '0) && (fields_i.vd != '0);
                end
                else
                begin
                    pe_o.operand = operand_f3;
                    vec_op       = 1'b1;
                    case (fields_i.funct6)
                        V_F6_ADD:
                        begin
                            pe_o.op = PE_ARITH_ADD;
                            if (reduction)
                            begin
                                pe_o.operand = PE_OPERAND_RIPPLE;
                                fix_vd_o     = 1'b1;
                            end
                        end
                        V_F6_SUB: pe_o.op = PE_ARITH_SUB;
                        V_F6_MIN:
                        begin
                            pe_o.op          = PE_ARITH_SUB;
                            pe_o.output_mode = PE_OP_MODE_PASS_MIN;
                        end
                        V_F6_MAX:
                        begin
                            pe_o.op          = PE_ARITH_SUB;
                            pe_o.output_mode = PE_OP_MODE_PASS_MAX;
                            if (reduction)
                            begin
                                pe_o.operand = PE_OPERAND_RIPPLE;
                                fix_vd_o     = 1'b1;
                            end
                        end
                        V_F6_AND: pe_o.op = PE_ARITH_AND;
                        V_F6_OR:  pe_o.op = PE_ARITH_OR;
                        V_F6_XOR: pe_o.op = PE_ARITH_XOR;
                        // vmv.x.s only returns element 0 of vs2 to the core
                        V_F6_WXUNARY0:
                        begin
                            csr_o.result_src = APU_RESULT_SRC_VS2_0;
                            vec_op           = 1'b0;
                        end
                        V_F6_MV:  pe_o.vd_data_src = VREG_WB_SRC_SCALAR;
                        // shared encoding, OPMVV selects multiply
                        V_F6_SLL_MUL:
                            pe_o.op = reduction ? PE_ARITH_MUL : PE_ARITH_LSHIFT;
                        V_F6_SRL: pe_o.op = PE_ARITH_RSHIFT_LOG;
                        V_F6_SRA: pe_o.op = PE_ARITH_RSHIFT_AR;
                        default:  vec_op = 1'b0;
                    endcase
                end
            end
            default:
                vec_op = 1'b0;
        endcase
    end
end

assign vreg_write_o = vec_op;
assign multi_beat_o = vec_op;
assign mem_op_o     = vlsu_o.load | vlsu_o.store;

endmodule

/* vdec_addr_gen.sv */
// register address generator, steps vs1/vs2/vd per beat and sizes the final write
`timescale 1ns/100ps
`include "vdec_params.svh"

module vdec_addr_gen
    import vdec_pkg::*;
(
    input  instr_fields_t           fields_i,
    input  logic [`VDEC_BEAT_W-1:0] beat_i,
    input  logic                    last_beat_i,
    input  sew_t                    sew_i,
    input  logic [`VDEC_VL_W-1:0]   vl_i,
    input  logic                    fix_vd_i,
    input  pe_operand_t             operand_i,
    input  vs3_addr_src_t           vs3_src_i,
    input  logic                    vreg_write_i,
    output vreg_ctrl_t              vreg_o,
    output logic [`VDEC_IMM_W-1:0]  immediate_o
);

logic [`VDEC_VREG_AW-1:0] step;

// 16-bit elements span two registers per beat
always_comb
begin
    if (sew_i == SEW_16)
        step = `VDEC_VREG_AW'({beat_i, 1'b0});
    else
        step = `VDEC_VREG_AW'(beat_i);
end

always_comb
begin
    vreg_o.vs1_addr = fields_i.vs1 + step;
    vreg_o.vs2_addr = fields_i.vs2 + step;
    // reductions and stores keep vd at its base
    vreg_o.vd_addr  = fix_vd_i ? fields_i.vd : fields_i.vd + step;
    vreg_o.vs3_src  = vs3_src_i;
    vreg_o.write    = vreg_write_i;

    vreg_o.elements_to_write = 2'd0;
    if (last_beat_i)
    begin
        // a reduction lands in one element
        if (operand_i == PE_OPERAND_RIPPLE)
            vreg_o.elements_to_write = 2'd1;
        else
            vreg_o.elements_to_write = vl_i[1:0];
    end
end

// vtype for vsetvli, otherwise the 5-bit simm/uimm field
assign immediate_o = (fields_i.major == V_MAJOR_OP_V && fields_i.funct3 == V_OPCFG) ?
                     fields_i.imm : `VDEC_IMM_W'(fields_i.vs1);

endmodule

/* vector_decoder.sv */
// vector accelerator decoder top level, sits on the core's APU port and drives the datapath
`timescale 1ns/100ps
`include "vdec_params.svh"

module vector_decoder
    import vdec_pkg::*;
(
    input  logic                   clk,
    input  logic                   n_reset,
    input  logic                   apu_req_i,
    input  apu_req_t               apu_data_i,
    input  logic [`VDEC_VL_W-1:0]  vl_i,
    input  sew_t                   sew_i,
    input  logic                   vlsu_done_i,
    output logic                   apu_gnt_o,
    output logic                   apu_rvalid_o,
    output logic                   core_halt_o,
    output logic [`VDEC_XLEN-1:0]  scalar1_o,
    output logic [`VDEC_XLEN-1:0]  scalar2_o,
    output logic [`VDEC_IMM_W-1:0] immediate_o,
    output pe_ctrl_t               pe_o,
    output csr_ctrl_t              csr_o,
    output vlsu_ctrl_t             vlsu_o,
    output vreg_ctrl_t             vreg_o
);

instr_fields_t           fields;
logic                    capture;
logic                    exec;
logic                    multi_beat;
logic                    mem_op;
logic [`VDEC_BEAT_W-1:0] beat;
logic                    last_beat;
vs3_addr_src_t           vs3_src;
logic                    vreg_write;
logic                    fix_vd;

vdec_instr_reg i_instr_reg (
    .clk        (clk),
    .n_reset    (n_reset),
    .capture_i  (capture),
    .apu_req_i  (apu_req_i),
    .apu_data_i (apu_data_i),
    .fields_o   (fields),
    .scalar1_o  (scalar1_o),
    .scalar2_o  (scalar2_o)
);

vdec_ctrl_fsm i_ctrl_fsm (
    .clk          (clk),
    .n_reset      (n_reset),
    .apu_req_i    (apu_req_i),
    .vlsu_done_i  (vlsu_done_i),
    .multi_beat_i (multi_beat),
    .mem_op_i     (mem_op),
    .vl_i         (vl_i),
    .capture_o    (capture),
    .exec_o       (exec),
    .apu_gnt_o    (apu_gnt_o),
    .apu_rvalid_o (apu_rvalid_o),
    .core_halt_o  (core_halt_o),
    .beat_o       (beat),
    .last_beat_o  (last_beat)
);

vdec_op_decode i_op_decode (
    .exec_i       (exec),
    .fields_i     (fields),
    .pe_o         (pe_o),
    .csr_o        (csr_o),
    .vlsu_o       (vlsu_o),
    .vs3_src_o    (vs3_src),
    .vreg_write_o (vreg_write),
    .fix_vd_o     (fix_vd),
    .multi_beat_o (multi_beat),
    .mem_op_o     (mem_op)
);

vdec_addr_gen i_addr_gen (
    .fields_i     (fields),
    .beat_i       (beat),
    .last_beat_i  (last_beat),
    .sew_i        (sew_i),
    .vl_i         (vl_i),
    .fix_vd_i     (fix_vd),
    .operand_i    (pe_o.operand),
    .vs3_src_i    (vs3_src),
    .vreg_write_i (vreg_write),
    .vreg_o       (vreg_o),
    .immediate_o  (immediate_o)
);

endmodule

/* vdec_asserts.sv */
// handshake and control assertions, bound to the vector decoder top level for simulation
`timescale 1ns/100ps

module vdec_asserts
    import vdec_pkg::*;
(
    input logic       clk,
    input logic       n_reset,
    input logic       apu_gnt_i,
    input logic       apu_rvalid_i,
    input logic       core_halt_i,
    input vlsu_ctrl_t vlsu_i,
    input vreg_ctrl_t vreg_i
);

// grant only while waiting, valid only while executing
gnt_valid_excl: assert property (@(posedge clk) disable iff (!n_reset)
    !(apu_gnt_i && apu_rvalid_i))
    else $error("apu grant and valid high together");

halt_not_gnt: assert property (@(posedge clk) disable iff (!n_reset)
    core_halt_i == !apu_gnt_i)
    else $error("core halt is not the inverse of grant");

load_store_excl: assert property (@(posedge clk) disable iff (!n_reset)
    !(vlsu_i.load && vlsu_i.store))
    else $error("vlsu load and store high together");

// element count without a write would be dropped
elems_need_write: assert property (@(posedge clk) disable iff (!n_reset)
    (vreg_i.elements_to_write != 2'd0) |-> vreg_i.write)
    else $error("elements to write set without write enable");

endmodule

bind vector_decoder vdec_asserts i_vdec_asserts (
    .clk          (clk),
    .n_reset      (n_reset),
    .apu_gnt_i    (apu_gnt_o),
    .apu_rvalid_i (apu_rvalid_o),
    .core_halt_i  (core_halt_o),
    .vlsu_i       (vlsu_o),
    .vreg_i       (vreg_o)
);

/* tb_vector_decoder.sv */
// directed testbench for the vector decoder that the Verilator Makefile builds from flist.f
`timescale 1ns/100ps
`include "vdec_params.svh"

module tb_vector_decoder
    import vdec_pkg::*;
;

localparam int CLK_PERIOD = 4;
// reset, config, vadd, vredsum, two memory ops, opcode table
localparam int TEST_CYCLES = 6 + 16 + 6 + 5 + 24 + 56;

logic                   clk;
logic                   n_reset;
logic                   apu_req;
apu_req_t               apu_data;
logic [`VDEC_VL_W-1:0]  vl;
sew_t                   sew;
logic                   vlsu_done;
logic                   apu_gnt;
logic                   apu_rvalid;
logic                   core_halt;
logic [`VDEC_XLEN-1:0]  scalar1;
logic [`VDEC_XLEN-1:0]  scalar2;
logic [`VDEC_IMM_W-1:0] immediate;
pe_ctrl_t               pe;
csr_ctrl_t              csr;
vlsu_ctrl_t             vlsu;
vreg_ctrl_t             vreg;
int                     errors;
int                     checks;
int                     seed;

vector_decoder i_vector_decoder (
    .clk          (clk),
    .n_reset      (n_reset),
    .apu_req_i    (apu_req),
    .apu_data_i   (apu_data),
    .vl_i         (vl),
    .sew_i        (sew),
    .vlsu_done_i  (vlsu_done),
    .apu_gnt_o    (apu_gnt),
    .apu_rvalid_o (apu_rvalid),
    .core_halt_o  (core_halt),
    .scalar1_o    (scalar1),
    .scalar2_o    (scalar2),
    .immediate_o  (immediate),
    .pe_o         (pe),
    .csr_o        (csr),
    .vlsu_o       (vlsu),
    .vreg_o       (vreg)
);

initial
    clk = 1'b0;

always #(CLK_PERIOD / 2) clk = ~clk;

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
        errors++;
        $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
    end
endtask

// vector instruction layout with the vm bit set (unmasked)
function automatic logic [31:0] encode_op(input logic [5:0] funct6, input logic [4:0] vs2,
                                          input logic [4:0] vs1, input logic [2:0] funct3,
                                          input logic [4:0] vd, input logic [6:0] major);
    return {funct6, 1'b1, vs2, vs1, funct3, vd, major};
endfunction

// returns on the capturing edge, so the next falling edge is the first EXEC cycle
task automatic send_request(input logic [31:0] instr, input logic [31:0] s1,
                            input logic [31:0] s2, input int vl_val, input sew_t sew_val);
    @(posedge clk);
    apu_req  <= 1'b1;
    apu_data <= {instr, s1, s2};
    vl       <= vl_val;
    sew      <= sew_val;
    @(negedge clk);
    if (!apu_gnt)
    begin
        errors++;
        $display("request at %0t ns was not granted, decoder still busy", $time);
    end
    @(posedge clk);
    apu_req <= 1'b0;
endtask

task automatic check_beats(input int n_beats, input int vs1_base, input int vs2_base,
                           input int vd_base, input int step, input int vd_step,
                           input int last_elems, input int exp_operand);
    int k;
    for (k = 0; k < n_beats; k++)
    begin
        @(negedge clk);
        check_value("vreg_o.vs1_addr", vreg.vs1_addr, vs1_base + step * k);
        check_value("vreg_o.vs2_addr", vreg.vs2_addr, vs2_base + step * k);
        check_value("vreg_o.vd_addr", vreg.vd_addr, vd_base + vd_step * k);
        check_value("vreg_o.elements_to_write", vreg.elements_to_write,
                    (k == n_beats - 1) ? last_elems : 0);
        check_value("vreg_o.write", vreg.write, 1);
        check_value("pe_o.operand", pe.operand, exp_operand);
        check_value("core_halt_o", core_halt, 1);
        check_value("apu_rvalid_o", apu_rvalid, k == n_beats - 1);
    end
endtask

task automatic test_reset_config();
    logic [31:0] s1;
    logic [31:0] s2;
    @(negedge clk);
    check_value("apu_gnt_o", apu_gnt, 1);
    check_value("apu_rvalid_o", apu_rvalid, 0);
    check_value("core_halt_o", core_halt, 0);
    check_value("vlsu_o", vlsu, 0);
    check_value("vreg_o.write", vreg.write, 0);
    s1 = $random(seed);
    s2 = $random(seed);
    // vsetvli x0, x0 keeps the current vl
    send_request({1'b0, 11'h0d3, 5'd0, 3'b111, 5'd0, 7'h57}, s1, s2, 4, SEW_32);
    @(negedge clk);
    check_value("apu_rvalid_o", apu_rvalid, 1);
    check_value("csr_o.write", csr.write, 1);
    check_value("csr_o.preserve_vl", csr.preserve_vl, 1);
    check_value("csr_o.set_vl_max", csr.set_vl_max, 0);
    check_value("immediate_o", immediate, 11'h0d3);
    check_value("scalar1_o", scalar1, s1);
    check_value("scalar2_o", scalar2, s2);
    // rd != x0 asks for vlmax
    send_request({1'b0, 11'h052, 5'd0, 3'b111, 5'd7, 7'h57}, s2, s1, 4, SEW_32);
    @(negedge clk);
    check_value("apu_rvalid_o", apu_rvalid, 1);
    check_value("csr_o.preserve_vl", csr.preserve_vl, 0);
    check_value("csr_o.set_vl_max", csr.set_vl_max, 1);
    check_value("immediate_o", immediate, 11'h052);
    check_value("scalar1_o", scalar1, s2);
    // second request held over the first EXEC cycle of a two-beat vadd
    send_request(encode_op(V_F6_ADD, 5'd8, 5'd4, V_OPIVV, 5'd16, V_MAJOR_OP_V), s1, s2, 8, SEW_32);
    apu_req  <= 1'b1;
    apu_data <= {32'hffff_ffff, ~s1, ~s2};
    @(negedge clk);
    check_value("apu_gnt_o", apu_gnt, 0);
    @(posedge clk);
    apu_req <= 1'b0;
    @(negedge clk);
    check_value("apu_rvalid_o", apu_rvalid, 1);
    check_value("scalar1_o", scalar1, s1);
    check_value("scalar2_o", scalar2, s2);
    check_value("vreg_o.vd_addr", vreg.vd_addr, 17);
    @(negedge clk);
    check_value("apu_gnt_o", apu_gnt, 1);
    check_value("core_halt_o", core_halt, 0);
endtask

task automatic run_mem_op(input logic [31:0] instr, input logic [3:0] exp_vlsu,
                          input int exp_vs2, input int exp_vd, input int exp_wb,
                          input int exp_vs3);
    int delay;
    int k;
    delay = 2 + ($unsigned($random(seed)) % 5);
    send_request(instr, $random(seed), $random(seed), 10, SEW_32);
    for (k = 0; k < delay; k++)
    begin
        @(negedge clk);
        check_value("vlsu_o", vlsu, exp_vlsu);
        check_value("vreg_o.vs2_addr", vreg.vs2_addr, exp_vs2);
        check_value("vreg_o.vd_addr", vreg.vd_addr, exp_vd);
        check_value("pe_o.vd_data_src", pe.vd_data_src, exp_wb);
        check_value("vreg_o.vs3_src", vreg.vs3_src, exp_vs3);
        check_value("core_halt_o", core_halt, 1);
        check_value("apu_rvalid_o", apu_rvalid, 0);
    end
    @(posedge clk);
    vlsu_done <= 1'b1;
    @(negedge clk);
    check_value("apu_rvalid_o", apu_rvalid, 1);
    check_value("vlsu_o", vlsu, exp_vlsu);
    @(posedge clk);
    vlsu_done <= 1'b0;
    @(negedge clk);
    check_value("apu_gnt_o", apu_gnt, 1);
endtask

// vl of 4 keeps every table entry to a single beat
task automatic check_opcode(input logic [5:0] funct6, input logic [2:0] funct3,
                            input int exp_op, input int exp_operand, input int exp_mode,
                            input int exp_src, input int exp_result, input int exp_write);
    send_request(encode_op(funct6, 5'd5, 5'd9, funct3, 5'd11, V_MAJOR_OP_V),
                 $random(seed), $random(seed), 4, SEW_32);
    @(negedge clk);
    check_value("pe_o.op", pe.op, exp_op);
    check_value("pe_o.operand", pe.operand, exp_operand);
    check_value("pe_o.output_mode", pe.output_mode, exp_mode);
    check_value("pe_o.vd_data_src", pe.vd_data_src, exp_src);
    check_value("csr_o.result_src", csr.result_src, exp_result);
    check_value("vreg_o.write", vreg.write, exp_write);
    check_value("apu_rvalid_o", apu_rvalid, 1);
    if (funct3 == V_OPIVI)
        check_value("immediate_o", immediate, 9);
endtask

task automatic test_opcode_table();
    check_opcode(V_F6_SUB, V_OPIVV, PE_ARITH_SUB, PE_OPERAND_VS1, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_MIN, V_OPIVX, PE_ARITH_SUB, PE_OPERAND_SCALAR, PE_OP_MODE_PASS_MIN,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_MAX, V_OPIVV, PE_ARITH_SUB, PE_OPERAND_VS1, PE_OP_MODE_PASS_MAX,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_AND, V_OPIVV, PE_ARITH_AND, PE_OPERAND_VS1, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_OR, V_OPIVX, PE_ARITH_OR, PE_OPERAND_SCALAR, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_XOR, V_OPIVI, PE_ARITH_XOR, PE_OPERAND_IMMEDIATE, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_SLL_MUL, V_OPIVI, PE_ARITH_LSHIFT, PE_OPERAND_IMMEDIATE,
                 PE_OP_MODE_RESULT, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_SLL_MUL, V_OPMVV, PE_ARITH_MUL, PE_OPERAND_VS1, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_SRL, V_OPIVV, PE_ARITH_RSHIFT_LOG, PE_OPERAND_VS1, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_SRA, V_OPIVX, PE_ARITH_RSHIFT_AR, PE_OPERAND_SCALAR, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 1);
    // vmv.v.i and vmv.v.x write the operand straight through
    check_opcode(V_F6_MV, V_OPIVI, PE_ARITH_ADD, PE_OPERAND_IMMEDIATE, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_SCALAR, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_MV, V_OPIVX, PE_ARITH_ADD, PE_OPERAND_SCALAR, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_SCALAR, APU_RESULT_SRC_VL, 1);
    check_opcode(V_F6_WXUNARY0, V_OPMVV, PE_ARITH_ADD, PE_OPERAND_VS1, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VS2_0, 0);
    // unsupported funct6 takes one beat and writes nothing
    check_opcode(6'b111111, V_OPIVV, PE_ARITH_ADD, PE_OPERAND_VS1, PE_OP_MODE_RESULT,
                 VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL, 0);
endtask

initial
begin
    seed      = 38;
    errors    = 0;
    checks    = 0;
    n_reset   = 1'b0;
    apu_req   = 1'b0;
    apu_data  = '0;
    vl        = 1;
    sew       = SEW_32;
    vlsu_done = 1'b0;
    repeat (5) @(posedge clk);
    n_reset <= 1'b1;

    test_reset_config();
    // vadd.vv with vl 10 at 32 bits takes three beats
    send_request(encode_op(V_F6_ADD, 5'd8, 5'd4, V_OPIVV, 5'd16, V_MAJOR_OP_V),
                 $random(seed), $random(seed), 10, SEW_32);
    check_beats(3, 4, 8, 16, 1, 1, 2, PE_OPERAND_VS1);
    // vredsum.vs with vl 7 at 16 bits steps by two registers
    send_request(encode_op(V_F6_ADD, 5'd10, 5'd2, V_OPMVV, 5'd20, V_MAJOR_OP_V),
                 $random(seed), $random(seed), 7, SEW_16);
    check_beats(2, 2, 10, 20, 2, 0, 1, PE_OPERAND_RIPPLE);
    // strided load then store
    // vlsu_o packs {en, load, store, strided}
    run_mem_op(encode_op(6'b000010, 5'd12, 5'd1, V_OPCFG, 5'd6, V_MAJOR_LOAD_FP), 4'b1101,
               12, 6, VREG_WB_SRC_MEMORY, VS3_ADDR_SRC_DECODE);
    run_mem_op(encode_op(6'b000000, 5'd0, 5'd3, V_OPCFG, 5'd14, V_MAJOR_STORE_FP), 4'b1010,
               0, 14, VREG_WB_SRC_ARITH, VS3_ADDR_SRC_VLSU);
    test_opcode_table();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
        $display(">>> PASS");
    else
        $display(">>> FAIL");
    $finish;
end

// watchdog allows twice the expected run length
initial
begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display(">>> FAIL");
    $finish;
end

endmodule

/* flist.f */
+incdir+.
vdec_pkg.sv
vdec_instr_reg.sv
vdec_ctrl_fsm.sv
vdec_op_decode.sv
vdec_addr_gen.sv
vector_decoder.sv
vdec_asserts.sv
tb_vector_decoder.sv

/* Makefile */
# Verilator build and run for the vector decoder testbench
# override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_vector_decoder
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the log holds the pass line
run: compile
	$(SIM_BIN) | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
